//--- verilog/core_types_pkg.sv
// Datapath widths, register count, operand-select codes and pipeline stage structs
`default_nettype none

package core_types_pkg;

	//////////////////////////////
	// Datapath sizes
	//////////////////////////////

	localparam int data_w  = 32;
	localparam int reg_cnt = 16;

	typedef logic [$clog2(reg_cnt)-1:0] reg_idx_t;
	typedef logic [data_w-1:0]          word_t;

	// Where an operand comes from
	// Immediate is only legal on operand B
	typedef enum logic [1:0] {
		sel_rf  = 2'd0,
		sel_imm = 2'd1,
		sel_ex  = 2'd2,
		sel_wb  = 2'd3
	} opsel_t;

	// ALU functions seen by the execute stage
	typedef enum logic [2:0] {
		alu_add   = 3'd0,
		alu_sub   = 3'd1,
		alu_and   = 3'd2,
		alu_or    = 3'd3,
		alu_xor   = 3'd4,
		alu_sll   = 3'd5,
		alu_passb = 3'd6
	} alu_op_t;

	//////////////////////////////
	// Stage structs
	//////////////////////////////

	// Decoded instruction handed from decode to the operand stage
	typedef struct packed {
		logic     valid;
		alu_op_t  alu_op;
		reg_idx_t rd;
		logic     wr_en;
		opsel_t   sel_a;
		opsel_t   sel_b;
		word_t    simm;
	} issue_t;

	// Destination of an instruction still in flight
	typedef struct packed {
		logic     valid;
		logic     wr_en;
		reg_idx_t rd;
	} dest_t;

	// Completed result leaving the core
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    value;
	} result_t;

endpackage

`default_nettype wire

//--- verilog/isa_pkg.sv
// Opcodes, ALU function codes and the instruction word with its R and I views
`default_nettype none

package isa_pkg;

	typedef logic [5:0] opcode_t;
	typedef logic [2:0] funct_t;

	// Register fields are five bits wide
	// Only the low four bits address the sixteen registers
	typedef logic [4:0] reg_field_t;

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	// Register-register ALU operation, function taken from funct
	localparam opcode_t op_alu_r = 6'h01;
	// Register-immediate add with a sign-extended imm16
	localparam opcode_t op_alu_i = 6'h02;
	// Any other opcode is a no-op without a register write

	// R-format function codes
	localparam funct_t fn_add   = 3'd0;
	localparam funct_t fn_sub   = 3'd1;
	localparam funct_t fn_and   = 3'd2;
	localparam funct_t fn_or    = 3'd3;
	localparam funct_t fn_xor   = 3'd4;
	localparam funct_t fn_sll   = 3'd5;
	localparam funct_t fn_passb = 3'd6;
	// Code 7 is reserved and decodes as a no-op

	//////////////////////////////
	// Instruction word
	//////////////////////////////

	typedef struct packed {
		opcode_t    opcode;
		reg_field_t rd;
		reg_field_t ra;
		reg_field_t rb;
		funct_t     funct;
		logic [7:0] unused;
	} insn_r_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_field_t  rd;
		reg_field_t  ra;
		logic [15:0] imm16;
	} insn_i_t;

	// Both views share opcode, rd and ra
	// The low half is rb plus funct in R, imm16 in I
	typedef union packed {
		insn_r_t r;
		insn_i_t i;
	} insn_u;

endpackage

`default_nettype wire

//--- verilog/insn_decode.sv
// Instruction register, field decode and forwarding-select logic
`default_nettype none

module insn_decode (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     insn_valid,
	input  wire isa_pkg::insn_u     insn,
	input  wire                     hold,
	input  wire core_types_pkg::dest_t ex_dest,
	input  wire core_types_pkg::dest_t wb_dest,
	output core_types_pkg::issue_t  issue,
	output core_types_pkg::reg_idx_t ra_addr,
	output core_types_pkg::reg_idx_t rb_addr
);
	import core_types_pkg::*;
	import isa_pkg::*;

	insn_u    insn_q;
	logic     valid_q;
	logic     is_r;
	logic     is_i;
	logic     funct_ok;
	alu_op_t  r_op;
	reg_idx_t rd;

	// Pick the newest producer of a source register
	// Register 0 never forwards since it always reads zero
	function automatic opsel_t fwd_sel(reg_idx_t src, dest_t ex_d, dest_t wb_d);
		if (src != '0 && ex_d.valid && ex_d.wr_en && ex_d.rd == src)
			return sel_ex;
		if (src != '0 && wb_d.valid && wb_d.wr_en && wb_d.rd == src)
			return sel_wb;
		return sel_rf;
	endfunction

	//////////////////////////////
	// Decode register
	//////////////////////////////

	// Frozen by hold, a missing strobe leaves a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			insn_q  <= '0;
			valid_q <= 1'b0;
		end else if (!hold) begin
			valid_q <= insn_valid;
			if (insn_valid)
				insn_q <= insn;
		end
	end

	//////////////////////////////
	// Field decode
	//////////////////////////////

	assign is_r = (insn_q.r.opcode == op_alu_r);
	assign is_i = (insn_q.r.opcode == op_alu_i);

	// Map R-format function code onto the ALU
	always_comb begin
		funct_ok = 1'b1;
		case (insn_q.r.funct)
			fn_add:   r_op = alu_add;
			fn_sub:   r_op = alu_sub;
			fn_and:   r_op = alu_and;
			fn_or:    r_op = alu_or;
			fn_xor:   r_op = alu_xor;
			fn_sll:   r_op = alu_sll;
			fn_passb: r_op = alu_passb;
			default: begin
				r_op     = alu_add;
				funct_ok = 1'b0;
			end
		endcase
	end

	// Shared fields read through the R view
	assign rd      = insn_q.r.rd[3:0];
	assign ra_addr = insn_q.r.ra[3:0];
	assign rb_addr = insn_q.r.rb[3:0];

	always_comb begin
		issue.valid  = valid_q;
		issue.alu_op = is_r ? r_op : alu_add;
		issue.rd     = rd;
		issue.wr_en  = valid_q && (is_i || (is_r && funct_ok));
		issue.sel_a  = fwd_sel(ra_addr, ex_dest, wb_dest);
		// I-format always takes the immediate on B
		issue.sel_b  = is_i ? sel_imm : fwd_sel(rb_addr, ex_dest, wb_dest);
		issue.simm   = {{(data_w-16){insn_q.i.imm16[15]}}, insn_q.i.imm16};
	end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
// Sixteen-entry register file with two bypassed read ports and one write port
`default_nettype none

module reg_file (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire core_types_pkg::reg_idx_t ra_addr,
	input  wire core_types_pkg::reg_idx_t rb_addr,
	input  wire                      wr_en,
	input  wire core_types_pkg::reg_idx_t wr_addr,
	input  wire core_types_pkg::word_t    wr_data,
	output core_types_pkg::word_t    rf_a,
	output core_types_pkg::word_t    rf_b
);
	import core_types_pkg::*;

	word_t regs [reg_cnt];

	// One read port
	// Register 0 is zero, a pending write is seen in the same cycle
	function automatic word_t read_port(reg_idx_t addr);
		if (addr == '0)
			return '0;
		if (wr_en && wr_addr == addr)
			return wr_data;
		return regs[addr];
	endfunction

	// Writes to register 0 are dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < reg_cnt; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Both ports follow the array and the write port as well as the address
	always_comb begin
		rf_a = read_port(ra_addr);
		rf_b = read_port(rb_addr);
	end

endmodule

`default_nettype wire

//--- verilog/operand_mux.sv
// Operand forwarding multiplexers and the hold-aware operand registers
`default_nettype none

module operand_mux (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    hold,
	input  wire core_types_pkg::issue_t issue,
	input  wire core_types_pkg::word_t  rf_a,
	input  wire core_types_pkg::word_t  rf_b,
	input  wire core_types_pkg::word_t  ex_fwd,
	input  wire core_types_pkg::word_t  wb_fwd,
	output core_types_pkg::word_t  operand_a,
	output core_types_pkg::word_t  operand_b,
	output core_types_pkg::issue_t op_issue
);
	import core_types_pkg::*;

	word_t muxed_a;
	word_t muxed_b;

	//////////////////////////////
	// Forwarding muxes
	//////////////////////////////

	// Operand A never selects the immediate
	always_comb begin
		case (issue.sel_a)
			sel_ex:  muxed_a = ex_fwd;
			sel_wb:  muxed_a = wb_fwd;
			default: muxed_a = rf_a;
		endcase
	end

	always_comb begin
		case (issue.sel_b)
			sel_imm: muxed_b = issue.simm;
			sel_ex:  muxed_b = ex_fwd;
			sel_wb:  muxed_b = wb_fwd;
			default: muxed_b = rf_b;
		endcase
	end

	//////////////////////////////
	// Operand registers
	//////////////////////////////

	// Nothing moves while hold is high
	// A bubble drops valid and keeps the last operands
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			operand_a <= '0;
			operand_b <= '0;
			op_issue  <= '0;
		end else if (!hold) begin
			if (issue.valid) begin
				operand_a <= muxed_a;
				operand_b <= muxed_b;
				op_issue  <= issue;
			end else begin
				op_issue.valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/alu_exec.sv
// ALU, execute-result and writeback registers, register-file write and result strobe
`default_nettype none

module alu_exec (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    hold,
	input  wire core_types_pkg::issue_t op_issue,
	input  wire core_types_pkg::word_t  operand_a,
	input  wire core_types_pkg::word_t  operand_b,
	output core_types_pkg::word_t  ex_fwd,
	output core_types_pkg::word_t  wb_fwd,
	output core_types_pkg::dest_t  ex_dest,
	output core_types_pkg::dest_t  wb_dest,
	output logic                   wr_en,
	output core_types_pkg::reg_idx_t wr_addr,
	output core_types_pkg::word_t  wr_data,
	output core_types_pkg::result_t result
);
	import core_types_pkg::*;

	word_t alu_res;
	// Execute-result stage
	dest_t xr_dest_q;
	word_t xr_value_q;
	// Writeback stage
	dest_t wb_dest_q;
	word_t wb_value_q;
	logic  wb_fire;

	//////////////////////////////
	// ALU
	//////////////////////////////

	always_comb begin
		case (op_issue.alu_op)
			alu_add:   alu_res = operand_a + operand_b;
			alu_sub:   alu_res = operand_a - operand_b;
			alu_and:   alu_res = operand_a & operand_b;
			alu_or:    alu_res = operand_a | operand_b;
			alu_xor:   alu_res = operand_a ^ operand_b;
			// Shift amount from the low bits of B only
			alu_sll:   alu_res = operand_a << operand_b[$clog2(data_w)-1:0];
			alu_passb: alu_res = operand_b;
			default:   alu_res = '0;
		endcase
	end

	// Distance-1 consumers take the ALU output directly
	assign ex_fwd  = alu_res;
	assign ex_dest = '{valid: op_issue.valid, wr_en: op_issue.wr_en, rd: op_issue.rd};

	//////////////////////////////
	// Pipeline registers
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			xr_dest_q <= '0;
			wb_dest_q <= '0;
		end else if (!hold) begin
			xr_dest_q <= ex_dest;
			wb_dest_q <= xr_dest_q;
		end
	end

	// Result values only move with a valid instruction
	always_ff @(posedge clk) begin
		if (!hold) begin
			if (op_issue.valid)
				xr_value_q <= alu_res;
			if (xr_dest_q.valid)
				wb_value_q <= xr_value_q;
		end
	end

	// Distance-2 consumers take the execute-result register
	assign wb_fwd  = xr_value_q;
	assign wb_dest = xr_dest_q;

	//////////////////////////////
	// Writeback
	//////////////////////////////

	// Held off during hold so each result strobes exactly once
	assign wb_fire = wb_dest_q.valid && wb_dest_q.wr_en && !hold;

	// Register file sees this write as a bypass for distance 3
	assign wr_en   = wb_fire;
	assign wr_addr = wb_dest_q.rd;
	assign wr_data = wb_value_q;

	assign result = '{valid: wb_fire, rd: wb_dest_q.rd, value: wb_value_q};

endmodule

`default_nettype wire

//--- verilog/mini_core.sv
// Top level of the three-stage pipeline slice connecting decode, operands, ALU and registers
`default_nettype none

module mini_core (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       insn_valid,
	input  wire isa_pkg::insn_u       insn,
	input  wire                       hold,
	output core_types_pkg::result_t   result
);
	import core_types_pkg::*;

	// Decode to operand stage
	issue_t   issue;
	reg_idx_t ra_addr;
	reg_idx_t rb_addr;
	word_t    rf_a;
	word_t    rf_b;

	// Operand stage to execute
	issue_t   op_issue;
	word_t    operand_a;
	word_t    operand_b;

	// Forwarding paths back from execute
	word_t    ex_fwd;
	word_t    wb_fwd;
	dest_t    ex_dest;
	dest_t    wb_dest;

	// Register-file write port
	logic     wr_en;
	reg_idx_t wr_addr;
	word_t    wr_data;

	//////////////////////////////
	// Stages
	//////////////////////////////

	insn_decode insn_decode_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.insn_valid (insn_valid),
		.insn       (insn),
		.hold       (hold),
		.ex_dest    (ex_dest),
		.wb_dest    (wb_dest),
		.issue      (issue),
		.ra_addr    (ra_addr),
		.rb_addr    (rb_addr)
	);

	reg_file reg_file_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rf_a    (rf_a),
		.rf_b    (rf_b)
	);

	operand_mux operand_mux_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.hold      (hold),
		.issue     (issue),
		.rf_a      (rf_a),
		.rf_b      (rf_b),
		.ex_fwd    (ex_fwd),
		.wb_fwd    (wb_fwd),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.op_issue  (op_issue)
	);

	alu_exec alu_exec_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.hold      (hold),
		.op_issue  (op_issue),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_fwd    (ex_fwd),
		.wb_fwd    (wb_fwd),
		.ex_dest   (ex_dest),
		.wb_dest   (wb_dest),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.result    (result)
	);

endmodule

`default_nettype wire

//--- dv/tb_mini_core.sv
// Testbench for mini_core with a file-driven program, reference model, result and register checks
`default_nettype none

module tb_mini_core;
	timeunit 1ns;
	timeprecision 100ps;

	import core_types_pkg::*;
	import isa_pkg::*;

	localparam int drain_limit = 200;

	logic    clk = 1'b0;
	logic    arst_n;
	logic    insn_valid;
	insn_u   insn;
	logic    hold;
	result_t result;

	// Reference register state and the final values from the stim file
	word_t model_regs [reg_cnt];
	word_t file_regs [reg_cnt];

	// Expected results in program order
	result_t exp_q [$];
	int      tick_q [$];
	bit      readout_q [$];
	word_t   file_q [$];

	// Count of edges on which the pipeline moved
	int adv_cnt;

	int result_errs;
	int word_errs;
	int timing_errs;
	int other_errs;

	// Monitor scratch
	result_t mon_exp;
	int      mon_tick;
	bit      mon_readout;

	mini_core mini_core_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.insn_valid (insn_valid),
		.insn       (insn),
		.hold       (hold),
		.result     (result)
	);

	always #2 clk = ~clk;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// R-format function on two source values
	function automatic word_t alu_ref(input funct_t fn, input word_t a, input word_t b);
		case (fn)
			fn_add:   return a + b;
			fn_sub:   return a - b;
			fn_and:   return a & b;
			fn_or:    return a | b;
			fn_xor:   return a ^ b;
			// Shift amount is B modulo 32
			fn_sll:   return a << b[4:0];
			fn_passb: return b;
			default:  return '0;
		endcase
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_result(input result_t got, input result_t exp);
		if (got.rd !== exp.rd) begin
			$display("[ERROR] %0t result.rd got %0d exp %0d", $time, got.rd, exp.rd);
			result_errs++;
		end
		if (got.value !== exp.value) begin
			$display("[ERROR] %0t result.value got %h exp %h", $time, got.value, exp.value);
			result_errs++;
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h exp %h", $time, name, got, exp);
			word_errs++;
		end
	endtask

	// Latency counted in edges with hold low
	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] %0t result latency got edge %0d exp edge %0d", $time, got, exp);
			timing_errs++;
		end
	endtask

	//////////////////////////////
	// Drivers
	//////////////////////////////

	task automatic idle_cycle();
		@(posedge clk);
		insn_valid <= 1'b0;
		hold       <= 1'b0;
	endtask

	// One strobe, then nhold frozen edges
	task automatic issue_insn(input insn_u w, input int nhold, input bit readout,
		input word_t fval);
		reg_idx_t rd;
		word_t    a;
		word_t    b;
		word_t    v;
		bit       writes;
		result_t  exp;

		rd     = w.r.rd[3:0];
		a      = model_regs[w.r.ra[3:0]];
		b      = model_regs[w.r.rb[3:0]];
		v      = '0;
		writes = 1'b0;
		// Function code 7 and unknown opcodes write nothing
		if (w.r.opcode == op_alu_r && w.r.funct != 3'd7) begin
			v      = alu_ref(w.r.funct, a, b);
			writes = 1'b1;
		end else if (w.i.opcode == op_alu_i) begin
			v      = a + {{16{w.i.imm16[15]}}, w.i.imm16};
			writes = 1'b1;
		end
		@(posedge clk);
		insn_valid <= 1'b1;
		insn       <= w;
		hold       <= 1'b0;
		if (writes) begin
			exp = '{valid: 1'b1, rd: rd, value: v};
			exp_q.push_back(exp);
			tick_q.push_back(adv_cnt + 4);
			readout_q.push_back(readout);
			if (readout)
				file_q.push_back(fval);
			// Register 0 stays zero in the model too
			if (rd != '0)
				model_regs[rd] = v;
		end
		if (nhold > 0) begin
			@(posedge clk);
			insn_valid <= 1'b0;
			hold       <= 1'b1;
			repeat (nhold - 1) @(posedge clk);
		end
	endtask

	task automatic wait_drain(input int limit);
		int n;

		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			idle_cycle();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout after %0d cycles with %0d results still missing", limit,
				exp_q.size());
			other_errs++;
		end
	endtask

	//////////////////////////////
	// Result monitor
	//////////////////////////////

	// Outputs are settled at the falling edge
	always @(negedge clk) begin
		if (arst_n) begin
			if (result.valid) begin
				if (exp_q.size() == 0) begin
					$display("Result strobe for register %0d at %0t with nothing pending",
						result.rd, $time);
					other_errs++;
				end else begin
					mon_exp     = exp_q.pop_front();
					mon_tick    = tick_q.pop_front();
					mon_readout = readout_q.pop_front();
					check_result(result, mon_exp);
					check_latency(adv_cnt, mon_tick);
					if (mon_readout)
						check_word($sformatf("result.value r%0d", mon_exp.rd), result.value,
							file_q.pop_front());
				end
			end
			// Hold seen here applies to the coming edge
			if (!hold)
				adv_cnt++;
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int    fd;
		int    code;
		int    nhold;
		int    gap;
		bit    got_end;
		string line;
		word_t raw;
		insn_u w;

		$timeformat(-9, 1, " ns", 0);
		arst_n      = 1'b0;
		insn_valid  = 1'b0;
		insn        = '0;
		hold        = 1'b0;
		adv_cnt     = 0;
		result_errs = 0;
		word_errs   = 0;
		timing_errs = 0;
		other_errs  = 0;
		got_end     = 1'b0;
		void'($urandom(28));
		for (int i = 0; i < reg_cnt; i++) begin
			model_regs[i] = '0;
			file_regs[i]  = '0;
		end
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		fd = $fopen("dv/core_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file dv/core_stim.txt");
			other_errs++;
		end else begin
			// Program lines go out back to back as they are read
			while (!got_end && !$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.getc(0) == "I") begin
					code = $sscanf(line, "I %h %d", raw, nhold);
					w    = raw;
					issue_insn(w, nhold, 1'b0, '0);
				end else if (code > 0 && line.getc(0) == "E") begin
					for (int i = 1; i < reg_cnt; i++)
						code = $fscanf(fd, "%h", file_regs[i]);
					got_end = 1'b1;
				end
			end
			$fclose(fd);
			idle_cycle();
			if (!got_end) begin
				$display("The stimulus file ended without an end marker");
				other_errs++;
			end
			wait_drain(drain_limit);

			// Model against the values listed in the file
			for (int i = 1; i < reg_cnt; i++)
				check_word($sformatf("model_regs[%0d]", i), model_regs[i], file_regs[i]);

			// Read out r1 to r15 with pass-b, random gaps between
			for (int r = 1; r < reg_cnt; r++) begin
				gap = $urandom_range(3, 0);
				repeat (gap) idle_cycle();
				w          = '0;
				w.r.opcode = op_alu_r;
				w.r.rd     = 5'(r);
				w.r.rb     = 5'(r);
				w.r.funct  = fn_passb;
				issue_insn(w, 0, 1'b1, file_regs[r]);
			end
			idle_cycle();
			wait_drain(drain_limit);
		end

		// Catch any late or extra strobe
		repeat (8) idle_cycle();
		$display("Error counts: result %0d, register %0d, latency %0d, other %0d",
			result_errs, word_errs, timing_errs, other_errs);
		if (result_errs + word_errs + timing_errs + other_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/core_stim.txt
# Column 1 is I for an instruction, column 2 its word in hex, column 3 the hold cycles after it
# E closes the program and is followed by the final r1 to r15 in hex, five per line
I 08200005 0  r1 = r0 + 5
I 0840FFFD 0  r2 = r0 - 3
I 04611000 0  r3 = r1 + r2
I 04830900 0  r4 = r3 - r1
I 04A11D00 3  r5 = r1 sll r3
I 04C52400 2  r6 = r5 xor r4
I 04E61200 0  r7 = r6 and r2
I 05053B00 1  r8 = r5 or r7
I 05204600 0  r9 = pass r8
I 04010800 0  r0 = r1 + r1 dropped
I 09407FFF 0  r10 = r0 + 7fff
I FD600000 0  no-op opcode
I 05610F00 0  reserved function code
I 096A8000 0  r11 = r10 - 8000
I 05805900 2  r12 = r0 - r11
I 09C00021 0  r14 = r0 + 21
I 05BB7500 1  r13 = r11 sll r14
I 05ED6000 0  r15 = r13 + r12
I 0863FFFF 0  r3 = r3 - 1
I 04231C00 0  r1 = r3 xor r3
E
00000000 fffffffd 00000001 fffffffd 00000014
ffffffe9 ffffffe9 fffffffd fffffffd 00007fff
ffffffff 00000001 fffffffe 00000021 ffffffff

//--- tb.f
verilog/core_types_pkg.sv
verilog/isa_pkg.sv
verilog/insn_decode.sv
verilog/reg_file.sv
verilog/operand_mux.sv
verilog/alu_exec.sv
verilog/mini_core.sv
dv/tb_mini_core.sv

//--- Makefile
# Verilator build and run for the mini_core testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mini_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TB PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
